// File: all.f
common/gb_cart_pkg.sv
verilog/cart_header.sv
mapper/mbc_regs.sv
mapper/rom_bank_map.sv
mapper/cram_bank.sv
verilog/cart_read_mux.sv
verilog/gb_cart_top.sv
dv/tb_gb_cart.sv

// File: run_sim.sh
#!/bin/sh
# compile the cartridge testbench with verilator, run it, scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_gb_cart -f all.f -o tb_gb_cart \
	> build.log 2>&1 \
	&& ./obj_dir/tb_gb_cart > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Test failures found" sim.log && { echo "simulation reported errors"; exit 1; }
grep -q "All tests passed!" sim.log \
	&& { echo "simulation clean"; exit 0; } \
	|| { echo "no result line in sim.log"; exit 1; }

// File: dv/tb_gb_cart.sv
// ---------------------------------------------------------------------
// directed testbench for the cartridge MBC: rom model, bus tasks,
// per-mapper tests, run timeout
// ---------------------------------------------------------------------
`timescale 1ns/1ps

module tb_gb_cart;
	import gb_cart_pkg::*;

	// six tests of well under 100 cycles each, the limit leaves a wide margin
	localparam int TIMEOUT_CYCLES = 4000;

	logic                   clk_sys;
	logic                   reset;
	logic                   dl_active;
	dl_word_t               dl;
	cart_bus_t              cpu;
	logic [15:0]            rom_data;
	logic [ROM_WADDR_W-1:0] rom_addr;
	logic                   rom_rd;
	logic [7:0]             cart_do;
	logic                   cart_ready;

	int          errors = 0;
	int          checks = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	int          test_err_start = 0;
	int          cycles = 0;
	logic [31:0] rng = 32'd6040;   // xorshift state
	logic [7:0]  ram_exp [4];      // one byte per mbc5 ram bank
	logic [7:0]  b3_byte;          // mbc3 bank 1 data, reused back to back
	logic [7:0]  b2b_byte;

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// rom contents: low 16 bits of addr * 0x9e37, plus the addr bits above bit 15
	// so that banks sharing their low address bits still hold different words
	function automatic logic [15:0] rom_word(input logic [ROM_WADDR_W-1:0] a);
		logic [37:0] p;
		p = {16'd0, a} * 38'h9e37 + {32'd0, a[21:16]};
		return p[15:0];
	endfunction

	// byte the cpu sees at addr with a 16k bank mapped: bank * 8192 words + a[13:1]
	function automatic logic [7:0] rom_byte_at(input logic [8:0] bank, input logic [15:0] addr);
		logic [15:0] w;
		w = rom_word({bank, addr[13:1]});
		return addr[0] ? w[15:8] : w[7:0];   // odd address is the high byte
	endfunction

	initial clk_sys = 1'b0;
	always #5 clk_sys = ~clk_sys;

	assign rom_data = rom_word(rom_addr);   // store answers in the same cycle

	gb_cart_top u_gb_cart_top (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.dl_active  (dl_active),
		.dl         (dl),
		.cpu        (cpu),
		.rom_data   (rom_data),
		.rom_addr   (rom_addr),
		.rom_rd     (rom_rd),
		.cart_do    (cart_do),
		.cart_ready (cart_ready)
	);

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Test failures found");
			$finish;
		end
	end

	// ---------------------------------------------------------------------
	// bus tasks
	// ---------------------------------------------------------------------
	task automatic check_eq(input string sig, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("[ERROR] %0t %s: expected %02h, got %02h", $time, sig, exp, got);
			errors++;
		end
	endtask

	task automatic drive_bus(input logic [15:0] a, input logic r, input logic w,
			input logic [7:0] d);
		cpu.addr  = a;
		cpu.rd    = r;
		cpu.wr    = w;
		cpu.wdata = d;
	endtask

	task automatic cpu_write(input logic [15:0] a, input logic [7:0] d);
		drive_bus(a, 1'b0, 1'b1, d);
		@(posedge clk_sys);
		#1;
		check_eq("rom_rd", {7'd0, rom_rd}, 8'h00);   // no rom read on a write
		drive_bus(16'h0000, 1'b0, 1'b0, 8'h00);   // bus idle
	endtask

	// read stays on the bus, so consecutive calls issue one read per cycle
	task automatic cpu_read_check(input logic [15:0] a, input logic [7:0] exp);
		drive_bus(a, 1'b1, 1'b0, 8'h00);
		@(posedge clk_sys);
		#1;
		check_eq("rom_rd", {7'd0, rom_rd}, 8'h01);   // follows the cpu read strobe
		check_eq($sformatf("cart_do @%04h", a), cart_do, exp);   // one clock later
	endtask

	// two header beats: type at 0x147, {ram size, rom size} at 0x148
	task automatic dl_header(input logic [7:0] cart_type, input logic [7:0] rom_sz,
			input logic [7:0] ram_sz);
		drive_bus(16'h0000, 1'b0, 1'b0, 8'h00);
		dl_active = 1'b1;      // mapper registers go back to reset
		@(posedge clk_sys);
		#1;
		dl.wr   = 1'b1;
		dl.addr = HDR_TYPE_OFS;
		dl.data = {cart_type, 8'h00};
		@(posedge clk_sys);
		#1;
		dl.addr = HDR_SIZE_OFS;
		dl.data = {ram_sz, rom_sz};
		@(posedge clk_sys);
		#1;
		dl.wr     = 1'b0;
		dl_active = 1'b0;
		@(posedge clk_sys);
		#1;
	endtask

	task automatic start_test();
		test_err_start = errors;
		tests_run++;
	endtask

	task automatic finish_test(input string name);
		if (errors == test_err_start) begin
			$display("test %-20s ok", name);
		end else begin
			$display("test %-20s FAILED with %0d errors", name, errors - test_err_start);
			tests_failed++;
		end
	endtask

	// ---------------------------------------------------------------------
	// tests
	// ---------------------------------------------------------------------
	task automatic readiness_no_mbc();
		logic [15:0] a;
		start_test();
		check_eq("cart_ready", {7'd0, cart_ready}, 8'h00);
		check_eq("cart_do", cart_do, 8'h00);
		cpu_read_check(16'h0150, 8'h00);   // no cartridge yet
		cpu_read_check(16'h4321, 8'h00);
		cpu_read_check(16'ha000, 8'h00);
		dl_header(8'd0, 8'd0, 8'd0);
		check_eq("cart_ready", {7'd0, cart_ready}, 8'h01);
		for (int i = 0; i < 16; i++) begin
			rng = xorshift32(rng);
			a   = {1'b0, rng[14:0]};
			cpu_read_check(a, rom_byte_at({8'd0, a[14]}, a));   // linear 32k
		end
		cpu_read_check(16'h7fff, rom_byte_at(9'd1, 16'h7fff));
		finish_test("readiness/no mbc");
	endtask

	task automatic mbc1_banking();
		start_test();
		dl_header(8'd1, 8'd2, 8'd3);       // 128k rom, mask 0x07
		cpu_write(16'h2000, 8'h00);        // 0 selects 1
		cpu_read_check(16'h4000, rom_byte_at(9'd1, 16'h4000));
		cpu_read_check(16'h0001, rom_byte_at(9'd0, 16'h0001));
		cpu_write(16'h2000, 8'h0d);        // 13 wraps to 5
		cpu_read_check(16'h6abd, rom_byte_at(9'd5, 16'h6abd));
		dl_header(8'd3, 8'd6, 8'd3);       // 2m rom, mask 0x7f
		cpu_write(16'h2000, 8'h03);
		cpu_write(16'h4000, 8'h02);        // ram bank bits become rom bits 6:5
		cpu_read_check(16'h5123, rom_byte_at(9'h043, 16'h5123));
		cpu_write(16'h6000, 8'h01);        // mode 1 drops them
		cpu_read_check(16'h5123, rom_byte_at(9'h003, 16'h5123));
		cpu_read_check(16'h2222, rom_byte_at(9'd0, 16'h2222));
		finish_test("mbc1");
	endtask

	task automatic mbc5_banking();
		start_test();
		dl_header(8'd25, 8'd8, 8'd3);      // 8m rom, mask 0x1ff
		cpu_write(16'h2000, 8'h00);        // bank 0 is legal here
		cpu_read_check(16'h4002, rom_byte_at(9'd0, 16'h4002));
		cpu_write(16'h2000, 8'h34);
		cpu_write(16'h3000, 8'h01);        // bit 8
		cpu_read_check(16'h7ffe, rom_byte_at(9'h134, 16'h7ffe));
		cpu_read_check(16'h4b0f, rom_byte_at(9'h134, 16'h4b0f));
		dl_header(8'd27, 8'd7, 8'd3);      // 4m rom, bit 8 masked off
		cpu_write(16'h3000, 8'h01);
		cpu_write(16'h2000, 8'h34);
		cpu_read_check(16'h4b0f, rom_byte_at(9'h034, 16'h4b0f));
		finish_test("mbc5");
	endtask

	task automatic mbc5_cart_ram();
		start_test();
		dl_header(8'd25, 8'd8, 8'd3);      // 32k ram, four banks
		cpu_read_check(16'ha123, 8'hff);   // ram still closed
		cpu_write(16'h0000, 8'h0a);
		for (int b = 0; b < 4; b++) begin
			rng        = xorshift32(rng);
			ram_exp[b] = rng[7:0];
			cpu_write(16'h4000, 8'(b));
			cpu_write(16'ha123, ram_exp[b]);
		end
		for (int b = 0; b < 8; b++) begin
			cpu_write(16'h4000, 8'(b));
			cpu_read_check(16'ha123, ram_exp[b & 3]);   // 4-7 alias onto 0-3
		end
		finish_test("mbc5 cart ram");
	endtask

	task automatic mbc2_mbc3_reads();
		start_test();
		dl_header(8'd6, 8'd1, 8'd0);       // mbc2, 4 bit ram
		cpu_write(16'h0000, 8'h0a);
		cpu_write(16'ha010, 8'h5c);
		cpu_read_check(16'ha010, 8'hfc);
		cpu_write(16'ha1ff, 8'h03);
		cpu_read_check(16'ha1ff, 8'hf3);
		dl_header(8'd19, 8'd2, 8'd3);      // mbc3, 32k ram
		cpu_write(16'h0000, 8'h0a);
		cpu_write(16'h4000, 8'h01);
		rng     = xorshift32(rng);
		b3_byte = rng[7:0];
		cpu_write(16'ha042, b3_byte);
		cpu_read_check(16'ha042, b3_byte);
		cpu_write(16'h4000, 8'h08);        // rtc register select
		cpu_read_check(16'ha042, 8'h00);
		cpu_write(16'h4000, 8'h01);        // back to ram bank 1
		cpu_read_check(16'ha042, b3_byte);
		finish_test("mbc2/mbc3 reads");
	endtask

	// mbc3 state from the previous test: ram bank 1 open, rom bank 1
	task automatic back_to_back_reads();
		start_test();
		rng      = xorshift32(rng);
		b2b_byte = rng[7:0];
		cpu_write(16'ha043, b2b_byte);
		cpu_read_check(16'ha043, b2b_byte);
		cpu_read_check(16'h1234, rom_byte_at(9'd0, 16'h1234));
		cpu_read_check(16'ha042, b3_byte);
		cpu_read_check(16'h5679, rom_byte_at(9'd1, 16'h5679));
		cpu_read_check(16'ha043, b2b_byte);
		cpu_read_check(16'h7ffe, rom_byte_at(9'd1, 16'h7ffe));
		cpu_read_check(16'ha042, b3_byte);
		cpu_read_check(16'h0001, rom_byte_at(9'd0, 16'h0001));
		drive_bus(16'h0000, 1'b0, 1'b0, 8'h00);
		finish_test("back to back reads");
	endtask

	initial begin
		reset     = 1'b1;
		dl_active = 1'b0;
		dl        = '0;
		cpu       = '0;
		repeat (5) @(posedge clk_sys);
		#1;
		reset = 1'b0;
		@(posedge clk_sys);
		#1;
		readiness_no_mbc();
		mbc1_banking();
		mbc5_banking();
		mbc5_cart_ram();
		mbc2_mbc3_reads();
		back_to_back_reads();
		$display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// File: verilog/gb_cart_top.sv
// ---------------------------------------------------------------------
// cartridge top: header capture, mbc registers, rom mapper, ram, read mux
// ---------------------------------------------------------------------
`timescale 1ns/1ps

module gb_cart_top (
	input  logic                                 clk_sys,
	input  logic                                 reset,
	input  logic                                 dl_active,  // rom download running
	input  gb_cart_pkg::dl_word_t                dl,
	input  gb_cart_pkg::cart_bus_t               cpu,
	input  logic [15:0]                          rom_data,
	output logic [gb_cart_pkg::ROM_WADDR_W-1:0] rom_addr,
	output logic                                 rom_rd,
	output logic [7:0]                           cart_do,
	output logic                                 cart_ready
);
	import gb_cart_pkg::*;

	cart_info_t  info;
	bank_state_t banks;
	cram_rsp_t   rsp;
	logic [7:0]  rom_byte;

	cart_header u_cart_header (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.dl         (dl),
		.info       (info),
		.cart_ready (cart_ready)
	);

	mbc_regs u_mbc_regs (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.dl_active (dl_active),
		.cpu       (cpu),
		.kind      (info.kind),
		.banks     (banks)
	);

	// rom and ram paths run side by side, the mux picks per read
	rom_bank_map u_rom_bank_map (
		.clk_sys  (clk_sys),
		.cpu      (cpu),
		.info     (info),
		.banks    (banks),
		.rom_data (rom_data),
		.rom_addr (rom_addr),
		.rom_rd   (rom_rd),
		.rom_byte (rom_byte)
	);

	cram_bank u_cram_bank (
		.clk_sys (clk_sys),
		.cpu     (cpu),
		.info    (info),
		.banks   (banks),
		.rsp     (rsp)
	);

	cart_read_mux u_cart_read_mux (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.cart_ready (cart_ready),
		.rom_byte   (rom_byte),
		.rsp        (rsp),
		.cart_do    (cart_do)
	);

endmodule

// File: verilog/cart_read_mux.sv
// ---------------------------------------------------------------------
// cpu read mux: ram response over rom byte, gated by cartridge ready
// ---------------------------------------------------------------------
`timescale 1ns/1ps

module cart_read_mux (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   cart_ready,
	input  logic [7:0]             rom_byte,
	input  gb_cart_pkg::cram_rsp_t rsp,
	output logic [7:0]             cart_do
);

	logic ready_q;   // readiness of the cycle that issued the read

	// rom_byte and rsp are already one cycle behind the request,
	// so the ready flag is delayed to line up with them
	always_ff @(posedge clk_sys) begin
		if (reset)
			ready_q <= 1'b0;
		else
			ready_q <= cart_ready;
	end

	always_comb begin
		if (!ready_q)
			cart_do = 8'h00;       // no cartridge yet
		else if (rsp.hit)
			cart_do = rsp.data;    // a000-bfff
		else
			cart_do = rom_byte;
	end

endmodule

// File: mapper/cram_bank.sv
// ---------------------------------------------------------------------
// cartridge ram: 128k array, banked address, enable/mbc2/rtc read rules
// ---------------------------------------------------------------------
`timescale 1ns/1ps

module cram_bank (
	input  logic                     clk_sys,
	input  gb_cart_pkg::cart_bus_t   cpu,
	input  gb_cart_pkg::cart_info_t  info,
	input  gb_cart_pkg::bank_state_t banks,
	output gb_cart_pkg::cram_rsp_t   rsp
);
	import gb_cart_pkg::*;

	localparam int CRAM_BYTES = 2 ** CRAM_ADDR_W;

	logic [7:0]             mem [CRAM_BYTES];
	logic [3:0]             bank_sel;    // 8k ram bank
	logic [CRAM_ADDR_W-1:0] cram_addr;
	logic                   in_range;    // a000-bfff
	logic                   mbc2_range;  // a000-a1ff, the 512x4 mbc2 ram
	logic [7:0]             q;
	logic [7:0]             rd_data;

	assign in_range   = (cpu.addr[15:13] == 3'b101);
	assign mbc2_range = (cpu.addr[15:9] == 7'b1010000);

	// ---------------------------------------------------------------------
	// bank select
	// ---------------------------------------------------------------------
	always_comb begin
		case (info.kind)
			MBC_1: begin
				// ram is only banked in 4/32 mode
				if (banks.mbc1_mode)
					bank_sel = {2'b00, banks.ram_bank[1:0] & info.ram_mask[1:0]};
				else
					bank_sel = 4'd0;
			end
			MBC_3:   bank_sel = {2'b00, banks.ram_bank[1:0] & info.ram_mask[1:0]};
			MBC_5:   bank_sel = banks.ram_bank & info.ram_mask;
			default: bank_sel = 4'd0;   // mbc2 and no-mbc see one bank
		endcase
	end

	assign cram_addr = {bank_sel, cpu.addr[12:0]};
	assign q         = mem[cram_addr];

	// read rules, first match wins
	always_comb begin
		if (!banks.ram_enable)
			rd_data = 8'hff;                  // closed ram floats high
		else if ((info.kind == MBC_2) && mbc2_range)
			rd_data = {4'hf, q[3:0]};         // only the low nibble exists
		else if (banks.rtc_mode)
			rd_data = 8'h00;                  // rtc regs not modelled
		else
			rd_data = q;
	end

	// writes land whether or not the ram is enabled
	always_ff @(posedge clk_sys) begin
		if (cpu.wr && in_range)
			mem[cram_addr] <= cpu.wdata;
	end

	always_ff @(posedge clk_sys) begin
		rsp.hit  <= cpu.rd && in_range;
		rsp.data <= rd_data;
	end

	// a write always lands on a known byte of the array
	a_wr_in_size: assert property (@(posedge clk_sys)
		(cpu.wr && in_range) |-> !$isunknown(cram_addr));

endmodule

// File: mapper/rom_bank_map.sv
// ---------------------------------------------------------------------
// rom bank mapper: per-kind bank select and mask, word address, byte pick
// ---------------------------------------------------------------------
`timescale 1ns/1ps

module rom_bank_map (
	input  logic                                 clk_sys,
	input  gb_cart_pkg::cart_bus_t               cpu,
	input  gb_cart_pkg::cart_info_t              info,
	input  gb_cart_pkg::bank_state_t             banks,
	input  logic [15:0]                          rom_data,
	output logic [gb_cart_pkg::ROM_WADDR_W-1:0] rom_addr,
	output logic                                 rom_rd,
	output logic [7:0]                           rom_byte
);
	import gb_cart_pkg::*;

	logic [6:0] mbc1_bank;   // mode-adjusted mbc1 bank before masking
	logic [8:0] bank;        // 16k bank
	logic [9:0] bank_field;  // 8k unit, bank plus a13

	always_comb begin
		// mode 0: ram bank bits drive rom a19/a20, mode 1: they go to the ram
		mbc1_bank = {banks.mbc1_mode ? 2'b00 : banks.ram_bank[1:0], banks.rom_bank[4:0]};

		case (info.kind)
			MBC_1:        bank = {2'b00, mbc1_bank & info.rom_mask[6:0]};
			MBC_2, MBC_3: bank = {2'b00, banks.rom_bank[6:0]};
			MBC_5:        bank = banks.rom_bank & info.rom_mask;
			default:      bank = {8'd0, cpu.addr[14]};     // plain 32k rom
		endcase

		if (!cpu.addr[14])
			bank = 9'd0;   // 0000-3fff is always bank 0
	end

	assign bank_field = {bank, cpu.addr[13]};
	assign rom_addr   = {bank_field, cpu.addr[12:1]};
	assign rom_rd     = cpu.rd;

	// store answers in the same cycle, latch the addressed byte
	always_ff @(posedge clk_sys) begin
		rom_byte <= cpu.addr[0] ? rom_data[15:8] : rom_data[7:0];
	end

endmodule

// File: mapper/mbc_regs.sv
// ---------------------------------------------------------------------
// mbc register file: cpu writes into rom/ram bank, mode, rtc select
// and ram enable
// ---------------------------------------------------------------------
`timescale 1ns/1ps

module mbc_regs (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  logic                     dl_active,
	input  gb_cart_pkg::cart_bus_t   cpu,
	input  gb_cart_pkg::mbc_kind_e   kind,
	output gb_cart_pkg::bank_state_t banks
);
	import gb_cart_pkg::*;

	logic [2:0] region;     // 8k region of the write
	logic       rom_bank_wr;
	logic       ram_bank_wr;

	assign region      = cpu.addr[15:13];
	assign rom_bank_wr = cpu.wr && (region == 3'b001);   // 2000-3fff
	assign ram_bank_wr = cpu.wr && (region == 3'b010);   // 4000-5fff

	always_ff @(posedge clk_sys) begin
		if (reset || dl_active) begin
			banks.rom_bank   <= 9'd1;   // bank 1 sits at 4000 on power up
			banks.ram_bank   <= 4'd0;
			banks.mbc1_mode  <= 1'b0;
			banks.rtc_mode   <= 1'b0;
			banks.ram_enable <= 1'b0;
		end else begin
			// 0000-1fff ram gate, any other value closes it again
			if (cpu.wr && (region == 3'b000))
				banks.ram_enable <= (cpu.wdata[3:0] == RAM_ENABLE_KEY);

			// rom bank
			if (rom_bank_wr) begin
				if (kind == MBC_5) begin
					if (cpu.addr[12])
						banks.rom_bank[8] <= cpu.wdata[0];     // 3xxx high bit
					else
						banks.rom_bank[7:0] <= cpu.wdata;      // 2xxx low byte
				end else if (cpu.wdata[6:0] == 7'd0) begin
					banks.rom_bank <= 9'd1;                    // bank 0 reads as 1
				end else begin
					banks.rom_bank <= {2'b00, cpu.wdata[6:0]};
				end
			end

			// ram bank, or rtc register select on mbc3
			if (ram_bank_wr) begin
				case (kind)
					MBC_3: begin
						if (cpu.wdata[3]) begin
							banks.rtc_mode <= 1'b1;
						end else begin
							banks.rtc_mode <= 1'b0;
							banks.ram_bank <= {2'b00, cpu.wdata[1:0]};
						end
					end
					MBC_5:   banks.ram_bank <= cpu.wdata[3:0];
					default: banks.ram_bank <= {2'b00, cpu.wdata[1:0]};
				endcase
			end

			// 6000-7fff banking mode, mbc1 only
			if ((kind == MBC_1) && cpu.wr && (region == 3'b011))
				banks.mbc1_mode <= cpu.wdata[0];
		end
	end

	// ---------------------------------------------------------------------
	// checks
	// ---------------------------------------------------------------------
	a_rd_wr_excl: assert property (@(posedge clk_sys) disable iff (reset)
		!(cpu.rd && cpu.wr));

	// only mbc5 may map rom bank 0 into 4000-7fff
	a_rom_bank_nz: assert property (@(posedge clk_sys) disable iff (reset)
		(kind != MBC_5) |-> (banks.rom_bank != 9'd0));

endmodule

// File: verilog/cart_header.sv
// ---------------------------------------------------------------------
// header capture from the rom download, mapper/size decode, ready flag
// ---------------------------------------------------------------------
`timescale 1ns/1ps

module cart_header (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  gb_cart_pkg::dl_word_t   dl,
	output gb_cart_pkg::cart_info_t info,
	output logic                    cart_ready
);
	import gb_cart_pkg::*;

	logic [7:0] type_byte;  // 0x147 cartridge type
	logic [7:0] rom_size;   // 0x148
	logic [7:0] ram_size;   // 0x149
	logic       hdr_beat;

	// only beats inside the header window are decoded
	assign hdr_beat = dl.wr && (dl.addr >= HDR_CGB_OFS) && (dl.addr <= HDR_SIZE_OFS);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			type_byte <= 8'h00;
			rom_size  <= 8'h00;
			ram_size  <= 8'h00;
		end else if (hdr_beat) begin
			if (dl.addr == HDR_TYPE_OFS)
				type_byte <= dl.data[15:8];         // odd byte of the word
			if (dl.addr == HDR_SIZE_OFS)
				{ram_size, rom_size} <= dl.data;
		end
	end

	// cart stays ready until the next reset, a new download just refills rom
	always_ff @(posedge clk_sys) begin
		if (reset)
			cart_ready <= 1'b0;
		else if (dl.wr)
			cart_ready <= 1'b1;
	end

	// ---------------------------------------------------------------------
	// decode
	// ---------------------------------------------------------------------
	always_comb begin
		case (type_byte) inside
			[8'd1:8'd3]:   info.kind = MBC_1;
			[8'd5:8'd6]:   info.kind = MBC_2;
			[8'd15:8'd19]: info.kind = MBC_3;   // with and without rtc
			[8'd25:8'd30]: info.kind = MBC_5;
			default:       info.kind = MBC_NONE;
		endcase

		// 2^(n+1) banks of 16k for n = 0..8, odd sizes ($52..) get 128 banks
		if (rom_size < 8'd9)
			info.rom_mask = 9'((10'd2 << rom_size[3:0]) - 10'd1);
		else
			info.rom_mask = 9'h07f;

		if (ram_size < 8'd3)
			info.ram_mask = 4'h0;   // none, 2k or 8k: single bank
		else if (ram_size == 8'd3)
			info.ram_mask = 4'h3;   // 32k
		else
			info.ram_mask = 4'hf;   // 128k
	end

	// download beats carry word pairs, so the byte address is always even
	a_dl_even: assert property (@(posedge clk_sys) disable iff (reset)
		dl.wr |-> !dl.addr[0]);

endmodule

// File: common/gb_cart_pkg.sv
// ---------------------------------------------------------------------
// cartridge package: widths, header offsets, mapper kinds and the
// structs shared by the MBC blocks
// ---------------------------------------------------------------------
package gb_cart_pkg;

	// ---------------------------------------------------------------------
	// widths
	// ---------------------------------------------------------------------
	localparam int CART_ADDR_W = 16;   // cpu address bus
	localparam int ROM_WADDR_W = 22;   // rom store, 16 bit words (8 MB)
	localparam int DL_ADDR_W   = 25;   // download stream byte address
	localparam int CRAM_ADDR_W = 17;   // up to 16 banks of 8 KB

	// header bytes, as byte offsets in the download stream
	localparam logic [DL_ADDR_W-1:0] HDR_CGB_OFS  = 25'h142;  // first header beat we look at
	localparam logic [DL_ADDR_W-1:0] HDR_TYPE_OFS = 25'h146;  // cartridge type in upper byte
	localparam logic [DL_ADDR_W-1:0] HDR_SIZE_OFS = 25'h148;  // {ram size, rom size}

	// low nibble written to 0x0000-0x1fff that opens the ram
	localparam logic [3:0] RAM_ENABLE_KEY = 4'ha;

	// ---------------------------------------------------------------------
	// types
	// ---------------------------------------------------------------------
	typedef enum int {
		MBC_NONE,   // 32k linear rom, no banking
		MBC_1,
		MBC_2,
		MBC_3,
		MBC_5
	} mbc_kind_e;

	// one cpu bus cycle
	typedef struct packed {
		logic [CART_ADDR_W-1:0] addr;
		logic                   rd;
		logic                   wr;
		logic [7:0]             wdata;
	} cart_bus_t;

	// one download beat, two rom bytes at an even address
	typedef struct packed {
		logic                 wr;
		logic [DL_ADDR_W-1:0] addr;
		logic [15:0]          data;
	} dl_word_t;

	// decoded header
	typedef struct packed {
		mbc_kind_e  kind;
		logic [8:0] rom_mask;   // 16k bank mask
		logic [3:0] ram_mask;   // 8k bank mask
	} cart_info_t;

	// mapper register state as written by the cpu
	typedef struct packed {
		logic [8:0] rom_bank;
		logic [3:0] ram_bank;
		logic       mbc1_mode;  // 0: 16/8 mode, 1: 4/32 mode
		logic       rtc_mode;   // mbc3 rtc selected at a000
		logic       ram_enable;
	} bank_state_t;

	// registered cartridge ram response
	typedef struct packed {
		logic       hit;        // last cycle was a read of a000-bfff
		logic [7:0] data;
	} cram_rsp_t;

endpackage
